// File: project.f
+incdir+.
fpu_pkg.sv
fpu_if.sv
fpu_operand_unpack.sv
fpu_mul.sv
fpu_cmp.sv
fpu_round.sv
fpu_top.sv
fpu_checker.sv
fpu_assertions.sv
fpu_tb.sv

// File: Bender.yml
package:
  name: bf16_fpu

export_include_dirs:
  - .

sources:
  - files:
      - fpu_pkg.sv
      - fpu_if.sv
      - fpu_operand_unpack.sv
      - fpu_mul.sv
      - fpu_cmp.sv
      - fpu_round.sv
      - fpu_top.sv
  - target: test
    files:
      - fpu_checker.sv
      - fpu_assertions.sv
      - fpu_tb.sv

// File: fpu_tb.sv
// testbench for fpu_top
// clock, reset, LCG stimulus biased toward special operands
// flush requests, random advance delay, watchdog and summary

`timescale 1ns/10ps

module fpu_tb;
	import fpu_pkg::*;

	localparam int CLK_PERIOD  = 40;
	localparam int DRIVE_DELAY = 2;
	localparam int NUM_TESTS   = 150;
	localparam int RESULT_WAIT = 8;

	logic        clk;
	logic        rst;
	logic        flush;
	logic        padv;
	opcode_t     opcode;
	rnd_mode_t   rnd_mode;
	float_t      op1;
	float_t      op2;
	float_t      result;
	logic        result_valid;
	logic        ready;
	logic [31:0] lcg_state;
	int          tb_errors;
	int          ops_issued;
	int          checker_errors;
	int          checker_results;
	int          total_errors;

	fpu_top i_fpu_top (
		.clk            (clk),
		.rst            (rst),
		.flush_i        (flush),
		.padv_i         (padv),
		.opcode_i       (opcode),
		.rnd_mode_i     (rnd_mode),
		.op1_i          (op1),
		.op2_i          (op2),
		.result_o       (result),
		.result_valid_o (result_valid),
		.ready_o        (ready)
	);

	fpu_checker i_checker (
		.clk            (clk),
		.rst            (rst),
		.flush_i        (flush),
		.padv_i         (padv),
		.opcode_i       (opcode),
		.rnd_mode_i     (rnd_mode),
		.op1_i          (op1),
		.op2_i          (op2),
		.result_i       (result),
		.result_valid_i (result_valid),
		.ready_i        (ready),
		.error_count_o  (checker_errors),
		.result_count_o (checker_results)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	////////////////////////////////////////////////////////////
	// stimulus helpers
	////////////////////////////////////////////////////////////

	function int unsigned lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return {16'h0000, lcg_state[31:16]};
	endfunction

	// zero, denormal, inf, NaN, overflow and underflow ranges, plain normals
	function float_t random_operand();
		int unsigned kind;
		int unsigned r;
		logic [7:0]  e;
		logic [6:0]  f;
		kind = lcg_next() % 10;
		r    = lcg_next();
		f    = r[6:0];
		case (kind)
			0:
			begin
				e = 8'd0;
				f = 7'd0;
			end
			1: e = 8'd0;
			2:
			begin
				e = 8'hFF;
				f = 7'd0;
			end
			3:
			begin
				e = 8'hFF;
				f = f | 7'd1;
			end
			4: e = 8'(200 + r % 55);
			5: e = 8'(1 + r % 50);
			default: e = 8'(96 + r % 64);
		endcase
		return '{sign: r[10], exp: e, frac: f};
	endfunction

	task automatic issue_op(input int num, input opcode_t op, input float_t a,
		input float_t b, input rnd_mode_t mode);
		int          cycles;
		int          hold;
		int          errs_before;
		int unsigned r;
		errs_before = checker_errors + tb_errors;
		opcode   = op;
		op1      = a;
		op2      = b;
		rnd_mode = mode;
		@(posedge clk);
		#DRIVE_DELAY;
		opcode = FPU_IDLE;
		cycles = 0;
		while (!result_valid && cycles < RESULT_WAIT)
		begin
			@(posedge clk);
			#DRIVE_DELAY;
			cycles++;
		end
		if (!result_valid)
		begin
			$display("test %0d: no result_valid_o within %0d cycles", num, RESULT_WAIT);
			tb_errors++;
		end
		else
		begin
			// back-pressure with new requests that must be ignored
			hold = lcg_next() % 4;
			repeat (hold)
			begin
				r = lcg_next();
				opcode = opcode_t'(3'(r % 5));
				@(posedge clk);
				#DRIVE_DELAY;
			end
			opcode = FPU_IDLE;
			padv   = 1'b1;
			@(posedge clk);
			#DRIVE_DELAY;
			padv = 1'b0;
		end
		$display("test %0d %s op1 %h op2 %h result %h %s", num, op.name(), a, b, result,
			(checker_errors + tb_errors == errs_before) ? "ok" : "error");
	endtask

	task automatic flush_op(input int num, input opcode_t op);
		int errs_before;
		errs_before = checker_errors + tb_errors;
		opcode = op;
		flush  = 1'b1;
		@(posedge clk);
		#DRIVE_DELAY;
		opcode = FPU_IDLE;
		flush  = 1'b0;
		repeat (4)
			@(posedge clk);
		#DRIVE_DELAY;
		$display("test %0d flush %s %s", num, op.name(),
			(checker_errors + tb_errors == errs_before) ? "ok" : "error");
	endtask

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////

	initial
	begin
		int unsigned kind;
		float_t      a;
		float_t      b;
		opcode_t     op;
		rnd_mode_t   mode;
		clk        = 1'b0;
		rst        = 1'b1;
		flush      = 1'b0;
		padv       = 1'b0;
		opcode     = FPU_IDLE;
		rnd_mode   = RND_NEAREST;
		op1        = '0;
		op2        = '0;
		lcg_state  = 32'd17;
		tb_errors  = 0;
		ops_issued = 0;
		repeat (3)
			@(posedge clk);
		#DRIVE_DELAY;
		rst = 1'b0;

		for (int t = 0; t < NUM_TESTS; t++)
		begin
			kind = lcg_next() % 10;
			a    = random_operand();
			b    = random_operand();
			// equal pairs and sign-flipped pairs
			case (lcg_next() % 6)
				0: b = a;
				1: b = '{sign: !a.sign, exp: a.exp, frac: a.frac};
				default: ;
			endcase
			mode = rnd_mode_t'(lcg_next() % 2);
			if (kind < 4)
				op = FPU_MUL;
			else if (kind < 6)
				op = FPU_EQ;
			else if (kind < 8)
				op = FPU_LT;
			else
				op = FPU_LE;
			if (lcg_next() % 8 == 0)
				flush_op(t, op);
			else
			begin
				issue_op(t, op, a, b, mode);
				ops_issued++;
			end
		end

		repeat (2)
			@(posedge clk);
		if (checker_results != ops_issued)
		begin
			$display("checker saw %0d results for %0d operations", checker_results, ops_issued);
			tb_errors++;
		end
		total_errors = tb_errors + checker_errors + i_fpu_top.i_fpu_assertions.failures;
		$display("tests %0d, operations %0d, results checked %0d, errors %0d",
			NUM_TESTS, ops_issued, checker_results, total_errors);
		if (total_errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

	// watchdog, 20 cycles per test
	initial
	begin
		#(NUM_TESTS * 20 * CLK_PERIOD);
		$display("watchdog expired before all tests finished");
		$display("*** FAILED ***");
		$finish;
	end

endmodule

// File: fpu_assertions.sv
// concurrent assertions on the fpu_top handshake
// latency, result hold, advance and flush behavior
// plus the bind into fpu_top

`timescale 1ns/10ps

module fpu_assertions (
	input logic                 clk,
	input logic                 rst,
	input logic                 flush_i,
	input logic                 padv_i,
	input fpu_pkg::opcode_t     opcode_i,
	input fpu_pkg::fpu_state_t  state_i,
	input fpu_pkg::float_t      result_i,
	input logic                 result_valid_i
);
	import fpu_pkg::*;

	int failures = 0;

	logic accept;

	assign accept = (state_i == S_IDLE) && (opcode_i != FPU_IDLE) && !flush_i;

	// result arrives two cycles after the accepting edge
	latency_two: assert property (@(posedge clk) disable iff (rst)
		accept |=> !result_valid_i [*2] ##1 result_valid_i)
	else
	begin
		$error("result_valid_o did not rise 2 cycles after acceptance");
		failures++;
	end

	hold_until_padv: assert property (@(posedge clk) disable iff (rst)
		result_valid_i && !padv_i |=> result_valid_i && $stable(result_i))
	else
	begin
		$error("result not held while padv_i is low");
		failures++;
	end

	fall_on_padv: assert property (@(posedge clk) disable iff (rst)
		result_valid_i && padv_i |=> !result_valid_i)
	else
	begin
		$error("result_valid_o did not fall after padv_i");
		failures++;
	end

	// a flushed request leaves the FSM idle
	flush_starts_nothing: assert property (@(posedge clk) disable iff (rst)
		(state_i == S_IDLE) && (opcode_i != FPU_IDLE) && flush_i |=> (state_i == S_IDLE))
	else
	begin
		$error("a request with flush_i high was accepted");
		failures++;
	end

endmodule

bind fpu_top fpu_assertions i_fpu_assertions (
	.clk            (clk),
	.rst            (rst),
	.flush_i        (flush_i),
	.padv_i         (padv_i),
	.opcode_i       (opcode_i),
	.state_i        (state_q),
	.result_i       (result_o),
	.result_valid_i (result_valid_o)
);

// File: fpu_checker.sv
// reference model and result checks for fpu_top
// integer model of the bfloat16 multiply with both rounding modes
// real-valued model of EQ, LT and LE, handshake and ready tracking

`timescale 1ns/10ps

`include "fpu_defs.svh"

module fpu_checker (
	input  logic               clk,
	input  logic               rst,
	input  logic               flush_i,
	input  logic               padv_i,
	input  fpu_pkg::opcode_t   opcode_i,
	input  fpu_pkg::rnd_mode_t rnd_mode_i,
	input  fpu_pkg::float_t    op1_i,
	input  fpu_pkg::float_t    op2_i,
	input  fpu_pkg::float_t    result_i,
	input  logic               result_valid_i,
	input  logic               ready_i,
	output int                 error_count_o,
	output int                 result_count_o
);
	import fpu_pkg::*;

	localparam int M_IDLE = 0;
	localparam int M_WORK = 1;
	localparam int M_DONE = 2;

	int          phase;
	int          work_cycles;
	logic        reported;
	logic [15:0] expected;
	opcode_t     cur_op;
	float_t      cur_a;
	float_t      cur_b;

	////////////////////////////////////////////////////////////
	// reference models
	////////////////////////////////////////////////////////////

	function automatic logic [15:0] model_mul(input logic [15:0] a, input logic [15:0] b,
		input logic trunc);
		int   ea;
		int   eb;
		int   e;
		int   p;
		int   shift;
		int   kept;
		int   rem;
		int   half;
		logic s;
		ea = a[14:7];
		eb = b[14:7];
		s  = a[15] ^ b[15];
		// NaN operand, or infinity times zero (denormals count as zero)
		if ((ea == 255 && a[6:0] != 0) || (eb == 255 && b[6:0] != 0) ||
			(ea == 255 && eb == 0) || (ea == 0 && eb == 255))
			return `FPU_QNAN;
		if (ea == 255 || eb == 255)
			return {s, 8'hFF, 7'h00};
		if (ea == 0 || eb == 0)
			return {s, 15'h0000};
		p = (128 + a[6:0]) * (128 + b[6:0]);
		e = ea + eb - `FPU_BIAS;
		shift = 7;
		if (p >= 32768)
		begin
			shift = 8;
			e = e + 1;
		end
		kept = p >> shift;
		rem  = p % (1 << shift);
		half = 1 << (shift - 1);
		if (!trunc && (rem > half || (rem == half && kept % 2 == 1)))
			kept = kept + 1;
		if (kept == 256)
		begin
			kept = 128;
			e = e + 1;
		end
		if (e >= 255)
			return {s, 8'hFF, 7'h00};
		if (e <= 0)
			return {s, 15'h0000};
		return {s, e[7:0], kept[6:0]};
	endfunction

	// infinity stands in as a value far above the bfloat16 range
	function automatic real to_real(input logic [15:0] f);
		int  e;
		real v;
		e = f[14:7];
		if (e == 0)
			v = 0.0;
		else if (e == 255)
			v = 1.0e300;
		else
			v = (1.0 + f[6:0] / 128.0) * (2.0 ** (e - `FPU_BIAS));
		return f[15] ? -v : v;
	endfunction

	function automatic logic model_cmp(input opcode_t op, input logic [15:0] a,
		input logic [15:0] b);
		real ra;
		real rb;
		if ((a[14:7] == 8'hFF && a[6:0] != 0) || (b[14:7] == 8'hFF && b[6:0] != 0))
			return 1'b0;
		ra = to_real(a);
		rb = to_real(b);
		case (op)
			FPU_EQ: return ra == rb;
			FPU_LT: return ra < rb;
			FPU_LE: return ra <= rb;
			default: return 1'b0;
		endcase
	endfunction

	task automatic value_error(input string name, input logic [15:0] got,
		input logic [15:0] want);
		$display("CHECK FAILED %s: got %h, expected %h (%s op1 %h op2 %h)",
			name, got, want, cur_op.name(), cur_a, cur_b);
		error_count_o++;
	endtask

	task automatic protocol_error(input string msg);
		$display("%s at %0t", msg, $time);
		error_count_o++;
	endtask

	////////////////////////////////////////////////////////////
	// handshake tracking
	////////////////////////////////////////////////////////////

	initial
	begin
		error_count_o  = 0;
		result_count_o = 0;
		phase          = M_IDLE;
		cur_op         = FPU_IDLE;
	end

	always @(posedge clk)
	begin
		if (rst)
			phase = M_IDLE;
		else
		begin
			if (ready_i !== ((opcode_i == FPU_IDLE) || result_valid_i))
				value_error("ready_o", ready_i, (opcode_i == FPU_IDLE) || result_valid_i);
			case (phase)
				M_IDLE:
				begin
					if (result_valid_i !== 1'b0)
						protocol_error("result_valid_o high with no operation in flight");
					if (opcode_i != FPU_IDLE && !flush_i)
					begin
						cur_op = opcode_i;
						cur_a  = op1_i;
						cur_b  = op2_i;
						if (opcode_i == FPU_MUL)
							expected = model_mul(op1_i, op2_i, rnd_mode_i == RND_TRUNC);
						else
							expected = {15'h0000, model_cmp(opcode_i, op1_i, op2_i)};
						work_cycles = 0;
						reported    = 1'b0;
						phase       = M_WORK;
					end
				end
				M_WORK:
				begin
					if (result_valid_i !== 1'b0)
						protocol_error("result_valid_o rose before 2 cycles");
					work_cycles++;
					if (work_cycles == 2)
						phase = M_DONE;
				end
				default:
				begin
					if (result_valid_i !== 1'b1)
					begin
						protocol_error("result_valid_o not high 2 cycles after acceptance");
						phase = M_IDLE;
					end
					else
					begin
						// checked every held cycle, so a changing result shows too
						if (result_i !== expected && !reported)
						begin
							value_error("result_o", result_i, expected);
							reported = 1'b1;
						end
						if (padv_i)
						begin
							result_count_o++;
							phase = M_IDLE;
						end
					end
				end
			endcase
		end
	end

endmodule

// File: fpu_top.sv
// top of the bfloat16 unit
// control FSM (idle, work, done), opcode decode and start strobes
// result select, output register and advance handshake

`timescale 1ns/10ps

module fpu_top (
	input  logic               clk,
	input  logic               rst,
	input  logic               flush_i,
	input  logic               padv_i,
	input  fpu_pkg::opcode_t   opcode_i,
	input  fpu_pkg::rnd_mode_t rnd_mode_i,
	input  fpu_pkg::float_t    op1_i,
	input  fpu_pkg::float_t    op2_i,
	output fpu_pkg::float_t    result_o,
	output logic               result_valid_o,
	output logic               ready_o
);
	import fpu_pkg::*;

	localparam int FLOAT_W = $bits(float_t);

	fpu_state_t state_q;
	fpu_state_t state_d;
	opcode_t    opcode_q;
	opcode_t    opcode_d;
	rnd_mode_t  rnd_mode_q;
	rnd_mode_t  rnd_mode_d;
	logic       do_mul_q;
	logic       do_mul_d;
	logic       do_eq_q;
	logic       do_eq_d;
	logic       do_lt_q;
	logic       do_lt_d;
	logic       do_le_q;
	logic       do_le_d;
	float_t     result_d;
	logic       result_valid_d;
	float_t     mul_result;
	logic       cmp_valid;
	logic       cmp_bit;

	fpu_operand_if op1_if ();
	fpu_operand_if op2_if ();
	fpu_result_if  mul_if ();

	////////////////////////////////////////////////////////////
	// state and output registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state_q        <= S_IDLE;
			opcode_q       <= FPU_IDLE;
			rnd_mode_q     <= RND_NEAREST;
			do_mul_q       <= 1'b0;
			do_eq_q        <= 1'b0;
			do_lt_q        <= 1'b0;
			do_le_q        <= 1'b0;
			result_o       <= '0;
			result_valid_o <= 1'b0;
		end
		else
		begin
			state_q        <= state_d;
			opcode_q       <= opcode_d;
			rnd_mode_q     <= rnd_mode_d;
			do_mul_q       <= do_mul_d;
			do_eq_q        <= do_eq_d;
			do_lt_q        <= do_lt_d;
			do_le_q        <= do_le_d;
			result_o       <= result_d;
			result_valid_o <= result_valid_d;
		end
	end

	////////////////////////////////////////////////////////////
	// control FSM
	////////////////////////////////////////////////////////////

	always_comb
	begin
		state_d        = state_q;
		opcode_d       = opcode_q;
		rnd_mode_d     = rnd_mode_q;
		do_mul_d       = 1'b0;
		do_eq_d        = 1'b0;
		do_lt_d        = 1'b0;
		do_le_d        = 1'b0;
		result_d       = result_o;
		result_valid_d = result_valid_o;

		case (state_q)
			S_IDLE:
			begin
				// flush drops the request before any unit starts
				if (opcode_i != FPU_IDLE && !flush_i)
				begin
					state_d    = S_WORK;
					opcode_d   = opcode_i;
					rnd_mode_d = rnd_mode_i;
					do_mul_d   = (opcode_i == FPU_MUL);
					do_eq_d    = (opcode_i == FPU_EQ);
					do_lt_d    = (opcode_i == FPU_LT);
					do_le_d    = (opcode_i == FPU_LE);
				end
			end
			S_WORK:
			begin
				case (opcode_q)
					FPU_MUL:
					begin
						if (mul_if.valid)
						begin
							result_d       = mul_result;
							result_valid_d = 1'b1;
							state_d        = S_DONE;
						end
					end
					FPU_EQ, FPU_LT, FPU_LE:
					begin
						if (cmp_valid)
						begin
							result_d       = float_t'({{(FLOAT_W-1){1'b0}}, cmp_bit});
							result_valid_d = 1'b1;
							state_d        = S_DONE;
						end
					end
					// unknown opcode, nothing was started
					default: state_d = S_IDLE;
				endcase
			end
			S_DONE:
			begin
				if (padv_i)
				begin
					result_valid_d = 1'b0;
					state_d        = S_IDLE;
				end
			end
			default: state_d = S_IDLE;
		endcase
	end

	assign ready_o = (opcode_i == FPU_IDLE) || result_valid_o;

	////////////////////////////////////////////////////////////
	// units
	////////////////////////////////////////////////////////////

	fpu_operand_unpack i_unpack (
		.clk   (clk),
		.rst   (rst),
		.op1_i (op1_i),
		.op2_i (op2_i),
		.op1_o (op1_if),
		.op2_o (op2_if)
	);

	fpu_mul i_mul (
		.clk      (clk),
		.rst      (rst),
		.do_mul_i (do_mul_q),
		.a_i      (op1_if),
		.b_i      (op2_if),
		.res_o    (mul_if)
	);

	fpu_cmp i_cmp (
		.clk     (clk),
		.rst     (rst),
		.do_eq_i (do_eq_q),
		.do_lt_i (do_lt_q),
		.do_le_i (do_le_q),
		.a_i     (op1_if),
		.b_i     (op2_if),
		.valid_o (cmp_valid),
		.cmp_o   (cmp_bit)
	);

	fpu_round i_round (
		.rnd_mode_i (rnd_mode_q),
		.res_i      (mul_if),
		.result_o   (mul_result)
	);

endmodule

// File: fpu_round.sv
// float rounding and repacking of a unit result
// round-to-nearest-even or truncate, carry renormalization
// overflow to infinity, underflow to zero, NaN to canonical NaN

`timescale 1ns/10ps

`include "fpu_defs.svh"

module fpu_round (
	input  fpu_pkg::rnd_mode_t rnd_mode_i,
	fpu_result_if.sink         res_i,
	output fpu_pkg::float_t    result_o
);
	import fpu_pkg::*;

	localparam int EXP_W   = `FPU_EXP_W + 2;
	localparam int EXP_MAX = (1 << `FPU_EXP_W) - 1;

	logic [`FPU_FRAC_W-1:0]  frac_t;
	logic                    guard;
	logic                    round_b;
	logic                    sticky;
	logic                    round_up;
	logic [`FPU_FRAC_W:0]    frac_sum;
	logic signed [EXP_W-1:0] exp_r;

	always_comb
	begin
		{frac_t, guard, round_b, sticky} = res_i.frac;
		// ties go to the even fraction
		round_up = (rnd_mode_i == RND_NEAREST) && guard && (round_b || sticky || frac_t[0]);
		frac_sum = {1'b0, frac_t} + {{`FPU_FRAC_W{1'b0}}, round_up};
		// carry out leaves a zero fraction and bumps the exponent
		exp_r    = res_i.exp + EXP_W'(frac_sum[`FPU_FRAC_W]);

		if (res_i.is_nan)
			result_o = `FPU_QNAN;
		else if (res_i.is_inf || exp_r >= EXP_MAX)
			result_o = '{sign: res_i.sign, exp: '1, frac: '0};
		else if (exp_r <= 0)
			result_o = '{sign: res_i.sign, exp: '0, frac: '0};
		else
			result_o = '{sign: res_i.sign, exp: exp_r[`FPU_EXP_W-1:0],
				frac: frac_sum[`FPU_FRAC_W-1:0]};
	end

endmodule

// File: fpu_cmp.sv
// bfloat16 comparator for EQ, LT and LE
// sign first, then magnitude, reversed for negative values
// +0 equals -0, any NaN gives 0

`timescale 1ns/10ps

`include "fpu_defs.svh"

module fpu_cmp (
	input  logic        clk,
	input  logic        rst,
	input  logic        do_eq_i,
	input  logic        do_lt_i,
	input  logic        do_le_i,
	fpu_operand_if.sink a_i,
	fpu_operand_if.sink b_i,
	output logic        valid_o,
	output logic        cmp_o
);
	localparam int MAG_W = `FPU_EXP_W + `FPU_FRAC_W;

	logic [MAG_W-1:0] mag_a;
	logic [MAG_W-1:0] mag_b;
	logic             any_nan;
	logic             both_zero;
	logic             eq;
	logic             lt;
	logic             cmp_d;

	always_comb
	begin
		// flushed operands already carry a zero significand
		mag_a     = {a_i.exp, a_i.sig[`FPU_FRAC_W-1:0]};
		mag_b     = {b_i.exp, b_i.sig[`FPU_FRAC_W-1:0]};
		any_nan   = a_i.is_nan || b_i.is_nan;
		both_zero = a_i.is_zero && b_i.is_zero;
		eq        = both_zero || ((a_i.sign == b_i.sign) && (mag_a == mag_b));

		if (both_zero)
			lt = 1'b0;
		else if (a_i.sign != b_i.sign)
			lt = a_i.sign;
		else if (a_i.sign)
			lt = (mag_a > mag_b);
		else
			lt = (mag_a < mag_b);

		cmp_d = !any_nan && ((do_eq_i && eq) || (do_lt_i && lt) || (do_le_i && (lt || eq)));
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			valid_o <= 1'b0;
		else
			valid_o <= do_eq_i || do_lt_i || do_le_i;
	end

	always_ff @(posedge clk)
	begin
		if (do_eq_i || do_lt_i || do_le_i)
			cmp_o <= cmp_d;
	end

endmodule

// File: fpu_mul.sv
// bfloat16 multiplier, one cycle from start to valid
// significand product, exponent sum, one-step normalization
// guard/round/sticky extraction and special-case flags

`timescale 1ns/10ps

`include "fpu_defs.svh"

module fpu_mul (
	input  logic         clk,
	input  logic         rst,
	input  logic         do_mul_i,
	fpu_operand_if.sink  a_i,
	fpu_operand_if.sink  b_i,
	fpu_result_if.source res_o
);
	localparam int SIG_W  = `FPU_FRAC_W + 1;
	localparam int PROD_W = 2 * SIG_W;
	localparam int EXP_W  = `FPU_EXP_W + 2;
	localparam int GRS_W  = `FPU_FRAC_W + 3;

	logic [PROD_W-1:0]       prod;
	logic signed [EXP_W-1:0] exp_sum;
	logic signed [EXP_W-1:0] exp_n;
	logic [GRS_W-1:0]        frac_n;
	logic                    nan_n;
	logic                    inf_n;
	logic                    zero_n;

	logic                    valid_q;
	logic                    sign_q;
	logic signed [EXP_W-1:0] exp_q;
	logic [GRS_W-1:0]        frac_q;
	logic                    nan_q;
	logic                    inf_q;

	////////////////////////////////////////////////////////////
	// product and normalization
	////////////////////////////////////////////////////////////

	always_comb
	begin
		prod    = a_i.sig * b_i.sig;
		exp_sum = EXP_W'(a_i.exp) + EXP_W'(b_i.exp) - EXP_W'(`FPU_BIAS);

		// product in [1,4), shift right once when the top bit is set
		if (prod[PROD_W-1])
		begin
			frac_n = {prod[PROD_W-2 -: `FPU_FRAC_W], prod[PROD_W-2-`FPU_FRAC_W],
				prod[PROD_W-3-`FPU_FRAC_W], |prod[PROD_W-4-`FPU_FRAC_W:0]};
			exp_n  = exp_sum + EXP_W'(1);
		end
		else
		begin
			frac_n = {prod[PROD_W-3 -: `FPU_FRAC_W], prod[PROD_W-3-`FPU_FRAC_W],
				prod[PROD_W-4-`FPU_FRAC_W], |prod[PROD_W-5-`FPU_FRAC_W:0]};
			exp_n  = exp_sum;
		end

		// inf times zero is invalid
		nan_n  = a_i.is_nan || b_i.is_nan || (a_i.is_inf && b_i.is_zero) ||
			(a_i.is_zero && b_i.is_inf);
		inf_n  = (a_i.is_inf || b_i.is_inf) && !nan_n;
		zero_n = a_i.is_zero || b_i.is_zero;

		// signed zero, rounder packs exponent 0 as zero
		if (zero_n)
		begin
			exp_n  = '0;
			frac_n = '0;
		end
	end

	////////////////////////////////////////////////////////////
	// output register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
			valid_q <= 1'b0;
		else
			valid_q <= do_mul_i;
	end

	always_ff @(posedge clk)
	begin
		if (do_mul_i)
		begin
			sign_q <= a_i.sign ^ b_i.sign;
			exp_q  <= exp_n;
			frac_q <= frac_n;
			nan_q  <= nan_n;
			inf_q  <= inf_n;
		end
	end

	assign res_o.valid  = valid_q;
	assign res_o.sign   = sign_q;
	assign res_o.exp    = exp_q;
	assign res_o.frac   = frac_q;
	assign res_o.is_nan = nan_q;
	assign res_o.is_inf = inf_q;

endmodule

// File: fpu_operand_unpack.sv
// operand unpacking for both operands
// splits fields, adds the hidden bit, classifies zero, infinity and NaN
// denormals are flushed to zero

`timescale 1ns/10ps

`include "fpu_defs.svh"

module fpu_operand_unpack (
	input  logic            clk,
	input  logic            rst,
	input  fpu_pkg::float_t op1_i,
	input  fpu_pkg::float_t op2_i,
	fpu_operand_if.source   op1_o,
	fpu_operand_if.source   op2_o
);
	import fpu_pkg::*;

	typedef struct packed {
		logic                   sign;
		logic [`FPU_EXP_W-1:0]  exp;
		logic [`FPU_FRAC_W:0]   sig;
		logic                   is_zero;
		logic                   is_inf;
		logic                   is_nan;
	} unpacked_t;

	unpacked_t op1_q;
	unpacked_t op2_q;

	function automatic unpacked_t unpack(input float_t f);
		unpacked_t u;
		logic      exp_max;
		exp_max   = &f.exp;
		u.sign    = f.sign;
		u.exp     = f.exp;
		// exponent zero covers denormals too
		u.is_zero = (f.exp == '0);
		u.is_inf  = exp_max && (f.frac == '0);
		u.is_nan  = exp_max && (f.frac != '0);
		u.sig     = u.is_zero ? '0 : {1'b1, f.frac};
		return u;
	endfunction

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			op1_q <= '0;
			op2_q <= '0;
		end
		else
		begin
			op1_q <= unpack(op1_i);
			op2_q <= unpack(op2_i);
		end
	end

	assign {op1_o.sign, op1_o.exp, op1_o.sig, op1_o.is_zero, op1_o.is_inf, op1_o.is_nan} = op1_q;
	assign {op2_o.sign, op2_o.exp, op2_o.sig, op2_o.is_zero, op2_o.is_inf, op2_o.is_nan} = op2_q;

endmodule

// File: fpu_if.sv
// interfaces inside the unit
// fpu_operand_if: one classified operand
// fpu_result_if: unrounded unit result with guard, round and sticky bits

`timescale 1ns/10ps

`include "fpu_defs.svh"

interface fpu_operand_if;
	logic                   sign;
	logic [`FPU_EXP_W-1:0]  exp;
	// significand with hidden bit, zero for flushed operands
	logic [`FPU_FRAC_W:0]   sig;
	logic                   is_zero;
	logic                   is_inf;
	logic                   is_nan;

	modport source (output sign, exp, sig, is_zero, is_inf, is_nan);
	modport sink (input sign, exp, sig, is_zero, is_inf, is_nan);
endinterface

interface fpu_result_if;
	// single-cycle strobe
	logic                          valid;
	logic                          sign;
	// two extra bits for overflow and underflow range
	logic signed [`FPU_EXP_W+1:0]  exp;
	// fraction, then guard, round, sticky
	logic [`FPU_FRAC_W+2:0]        frac;
	logic                          is_nan;
	logic                          is_inf;

	modport source (output valid, sign, exp, frac, is_nan, is_inf);
	modport sink (input valid, sign, exp, frac, is_nan, is_inf);
endinterface

// File: fpu_pkg.sv
// types shared by the bfloat16 unit
// packed float, opcodes, rounding modes, control FSM states

`include "fpu_defs.svh"

package fpu_pkg;

	// packed bfloat16 word
	typedef struct packed {
		logic                   sign;
		logic [`FPU_EXP_W-1:0]  exp;
		logic [`FPU_FRAC_W-1:0] frac;
	} float_t;

	// operations, FPU_IDLE means no request
	typedef enum logic [2:0] {
		FPU_IDLE = 3'd0,
		FPU_MUL  = 3'd1,
		FPU_EQ   = 3'd2,
		FPU_LT   = 3'd3,
		FPU_LE   = 3'd4
	} opcode_t;

	typedef enum logic {
		RND_NEAREST = 1'b0,
		RND_TRUNC   = 1'b1
	} rnd_mode_t;

	// control FSM
	typedef enum logic [1:0] {
		S_IDLE = 2'd0,
		S_WORK = 2'd1,
		S_DONE = 2'd2
	} fpu_state_t;

endpackage

// File: fpu_defs.svh
// bfloat16 format parameters
// exponent and fraction widths, exponent bias, canonical quiet NaN

`ifndef FPU_DEFS_SVH
`define FPU_DEFS_SVH

////////////////////////////////////////////////////////////
// format
////////////////////////////////////////////////////////////

// 1 sign bit, 8 exponent bits, 7 fraction bits
`define FPU_EXP_W 8
`define FPU_FRAC_W 7

// exponent bias
`define FPU_BIAS 127

////////////////////////////////////////////////////////////
// special encodings
////////////////////////////////////////////////////////////

// quiet NaN returned by every invalid operation
`define FPU_QNAN 16'h7FC0

`endif
